//--- source/periph_xbar_pkg.sv
/*
 * Shared constants for the peripheral crossbar
 * Bus widths, the cluster address map and the peripheral port indices
 */

package periph_xbar_pkg;

  // Bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // Top address byte of the cluster
  localparam logic [7:0] CLUSTER_BASE = 8'h10;

  // Address bits 23:20 that select the peripheral region
  localparam logic [3:0] PERIPH_REGION_LO = 4'h2;
  localparam logic [3:0] PERIPH_REGION_HI = 4'h3;

  // Address bits that carry the peripheral index
  localparam int unsigned ROUTING_LSB = 16;
  localparam int unsigned ROUTING_MSB = 19;

  // Event unit owns several plugs that share one port
  localparam int unsigned SPER_EVENT_U_ID     = 2;
  localparam int unsigned NB_SPERIPH_PLUGS_EU = 2;

  // Accelerator port, decoded to the error port when absent
  localparam int unsigned SPER_HWPE_ID = 4;

  // Everything outside the cluster
  localparam int unsigned SPER_EXT_ID = 6;

  // Catches in-cluster addresses that hit no peripheral
  localparam int unsigned SPER_ERROR_ID = 7;

endpackage

//--- source/periph_addr_decode.sv
/*
 * Address decoder for one master of the peripheral crossbar
 * Turns the request address into a one-hot slave request vector
 */

`timescale 1ns/1ps

module periph_addr_decode #(
  parameter int unsigned NB_SLAVES          = 8,
  parameter bit          HWPE_PRESENT       = 1'b1,
  parameter bit          CLUSTER_ALIAS      = 1'b0,
  parameter logic [11:0] CLUSTER_ALIAS_BASE = 12'h000
) (
  input  logic                                  req_i,
  input  logic [periph_xbar_pkg::ADDR_WIDTH-1:0] add_i,
  output logic [NB_SLAVES-1:0]                  slave_req_o
);

  localparam int unsigned IDX_W   = $clog2(NB_SLAVES);
  localparam int unsigned FIELD_W = periph_xbar_pkg::ROUTING_MSB -
                                    periph_xbar_pkg::ROUTING_LSB + 1;

  logic               in_cluster;
  logic               in_region;
  logic [FIELD_W-1:0] field;
  logic [IDX_W-1:0]   sel_idx;

  // Own cluster, or its alias window when aliasing is enabled
  assign in_cluster = (add_i[31:24] == periph_xbar_pkg::CLUSTER_BASE) ||
                      (CLUSTER_ALIAS && (add_i[31:24] == CLUSTER_ALIAS_BASE[11:4]));

  assign in_region = (add_i[23:20] >= periph_xbar_pkg::PERIPH_REGION_LO) &&
                     (add_i[23:20] <= periph_xbar_pkg::PERIPH_REGION_HI);

  assign field = add_i[periph_xbar_pkg::ROUTING_MSB:periph_xbar_pkg::ROUTING_LSB];

  always_comb begin
    if (!in_cluster) begin
      sel_idx = IDX_W'(periph_xbar_pkg::SPER_EXT_ID);
    end else if (in_region && (add_i[23:20] == periph_xbar_pkg::PERIPH_REGION_LO) &&
                 (field < NB_SLAVES)) begin
      if ((field >= periph_xbar_pkg::SPER_EVENT_U_ID) &&
          (field < periph_xbar_pkg::SPER_EVENT_U_ID +
                   periph_xbar_pkg::NB_SPERIPH_PLUGS_EU)) begin
        // All event unit plugs share a single port
        sel_idx = IDX_W'(periph_xbar_pkg::SPER_EVENT_U_ID);
      end else if (!HWPE_PRESENT && (field == periph_xbar_pkg::SPER_HWPE_ID)) begin
        sel_idx = IDX_W'(periph_xbar_pkg::SPER_ERROR_ID);
      end else begin
        sel_idx = IDX_W'(field);
      end
    end else begin
      // In cluster but not a valid peripheral
      sel_idx = IDX_W'(periph_xbar_pkg::SPER_ERROR_ID);
    end
  end

  always_comb begin
    for (int s = 0; s < NB_SLAVES; s++) begin
      slave_req_o[s] = req_i && (sel_idx == IDX_W'(s));
    end
  end

endmodule

//--- source/periph_rr_arbiter.sv
/*
 * Round-robin arbiter for one slave port of the peripheral crossbar
 * Picks a requesting master, muxes its fields and one-hot id to the slave
 * and returns the slave grant to the winner
 */

`timescale 1ns/1ps

module periph_rr_arbiter #(
  parameter int unsigned NB_MASTERS = 4
) (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  logic [NB_MASTERS-1:0]                                  req_i,
  input  logic [NB_MASTERS-1:0][periph_xbar_pkg::ADDR_WIDTH-1:0] add_i,
  input  logic [NB_MASTERS-1:0]                                  wen_i,
  input  logic [NB_MASTERS-1:0][periph_xbar_pkg::DATA_WIDTH-1:0] wdata_i,
  input  logic [NB_MASTERS-1:0][periph_xbar_pkg::BE_WIDTH-1:0]   be_i,
  output logic [NB_MASTERS-1:0]                                  gnt_o,
  input  logic                                                   gnt_i,
  output logic                                                   req_o,
  output logic [periph_xbar_pkg::ADDR_WIDTH-1:0]                 add_o,
  output logic                                                   wen_o,
  output logic [periph_xbar_pkg::DATA_WIDTH-1:0]                 wdata_o,
  output logic [periph_xbar_pkg::BE_WIDTH-1:0]                   be_o,
  output logic [NB_MASTERS-1:0]                                  id_o
);

  localparam int unsigned IDX_W = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;

  logic [IDX_W-1:0]      rr_q;
  logic [IDX_W-1:0]      winner_idx;
  logic [NB_MASTERS-1:0] winner_oh;

  assign req_o = |req_i;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int  cand;
    logic found;
    found      = 1'b0;
    winner_idx = '0;
    for (int off = 0; off < NB_MASTERS; off++) begin
      cand = (int'(rr_q) + off) % NB_MASTERS;
      if (!found && req_i[cand]) begin
        found      = 1'b1;
        winner_idx = IDX_W'(cand);
      end
    end
  end

  always_comb begin
    winner_oh = '0;
    if (req_o) begin
      winner_oh[winner_idx] = 1'b1;
    end
  end

  assign add_o   = add_i[winner_idx];
  assign wen_o   = wen_i[winner_idx];
  assign wdata_o = wdata_i[winner_idx];
  assign be_o    = be_i[winner_idx];
  assign id_o    = winner_oh;

  // Grant only reaches the chosen master
  assign gnt_o = winner_oh & {NB_MASTERS{gnt_i}};

  // Pointer moves past the winner once the slave takes the request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= '0;
    end else if (req_o && gnt_i) begin
      if (winner_idx == IDX_W'(NB_MASTERS - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= winner_idx + 1'b1;
      end
    end
  end

endmodule

//--- source/periph_resp_router.sv
/*
 * Response router for one master of the peripheral crossbar
 * Picks the slave response whose echoed id carries this master's bit
 */

`timescale 1ns/1ps

module periph_resp_router #(
  parameter int unsigned NB_MASTERS = 4,
  parameter int unsigned NB_SLAVES  = 8,
  parameter int unsigned MASTER_IDX = 0
) (
  input  logic [NB_SLAVES-1:0]                                  r_valid_i,
  input  logic [NB_SLAVES-1:0][NB_MASTERS-1:0]                  r_id_i,
  input  logic [NB_SLAVES-1:0][periph_xbar_pkg::DATA_WIDTH-1:0] r_rdata_i,
  input  logic [NB_SLAVES-1:0]                                  r_opc_i,
  output logic                                                  r_valid_o,
  output logic [periph_xbar_pkg::DATA_WIDTH-1:0]                r_rdata_o,
  output logic                                                  r_opc_o
);

  logic [NB_SLAVES-1:0] hit;

  always_comb begin
    for (int s = 0; s < NB_SLAVES; s++) begin
      hit[s] = r_valid_i[s] && r_id_i[s][MASTER_IDX];
    end
  end

  // One outstanding request per master, so at most one hit per cycle
  assign r_valid_o = |hit;

  always_comb begin
    logic found;
    found     = 1'b0;
    r_rdata_o = '0;
    r_opc_o   = 1'b0;
    for (int s = 0; s < NB_SLAVES; s++) begin
      if (!found && hit[s]) begin
        found     = 1'b1;
        r_rdata_o = r_rdata_i[s];
        r_opc_o   = r_opc_i[s];
      end
    end
  end

endmodule

//--- source/periph_xbar.sv
/*
 * Peripheral crossbar top level
 * One address decoder and one response router per master,
 * one round-robin arbiter per slave port
 */

`timescale 1ns/1ps

module periph_xbar #(
  parameter int unsigned NB_MASTERS         = 4,
  parameter int unsigned NB_SLAVES          = 8,
  parameter bit          HWPE_PRESENT       = 1'b1,
  parameter bit          CLUSTER_ALIAS      = 1'b0,
  parameter logic [11:0] CLUSTER_ALIAS_BASE = 12'h000
) (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  // Master side
  input  logic [NB_MASTERS-1:0]                                 m_req_i,
  input  logic [NB_MASTERS-1:0][periph_xbar_pkg::ADDR_WIDTH-1:0] m_add_i,
  input  logic [NB_MASTERS-1:0]                                 m_wen_i,
  input  logic [NB_MASTERS-1:0][periph_xbar_pkg::DATA_WIDTH-1:0] m_wdata_i,
  input  logic [NB_MASTERS-1:0][periph_xbar_pkg::BE_WIDTH-1:0]  m_be_i,
  output logic [NB_MASTERS-1:0]                                 m_gnt_o,
  output logic [NB_MASTERS-1:0]                                 m_r_valid_o,
  output logic [NB_MASTERS-1:0][periph_xbar_pkg::DATA_WIDTH-1:0] m_r_rdata_o,
  output logic [NB_MASTERS-1:0]                                 m_r_opc_o,
  // Slave side
  output logic [NB_SLAVES-1:0]                                  s_req_o,
  output logic [NB_SLAVES-1:0][periph_xbar_pkg::ADDR_WIDTH-1:0] s_add_o,
  output logic [NB_SLAVES-1:0]                                  s_wen_o,
  output logic [NB_SLAVES-1:0][periph_xbar_pkg::DATA_WIDTH-1:0] s_wdata_o,
  output logic [NB_SLAVES-1:0][periph_xbar_pkg::BE_WIDTH-1:0]   s_be_o,
  output logic [NB_SLAVES-1:0][NB_MASTERS-1:0]                  s_id_o,
  input  logic [NB_SLAVES-1:0]                                  s_gnt_i,
  input  logic [NB_SLAVES-1:0]                                  s_r_valid_i,
  input  logic [NB_SLAVES-1:0][NB_MASTERS-1:0]                  s_r_id_i,
  input  logic [NB_SLAVES-1:0][periph_xbar_pkg::DATA_WIDTH-1:0] s_r_rdata_i,
  input  logic [NB_SLAVES-1:0]                                  s_r_opc_i
);

  // Rows indexed by master, columns by slave
  logic [NB_MASTERS-1:0][NB_SLAVES-1:0] req_mtx;
  logic [NB_MASTERS-1:0][NB_SLAVES-1:0] gnt_mtx;
  // Same matrices seen from the slave side
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] arb_req;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] arb_gnt;

  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_masters
    periph_addr_decode #(
      .NB_SLAVES          (NB_SLAVES),
      .HWPE_PRESENT       (HWPE_PRESENT),
      .CLUSTER_ALIAS      (CLUSTER_ALIAS),
      .CLUSTER_ALIAS_BASE (CLUSTER_ALIAS_BASE)
    ) u_decode (
      .req_i       (m_req_i[m]),
      .add_i       (m_add_i[m]),
      .slave_req_o (req_mtx[m])
    );

    // A master targets one slave, so at most one column can grant it
    assign m_gnt_o[m] = |gnt_mtx[m];

    periph_resp_router #(
      .NB_MASTERS (NB_MASTERS),
      .NB_SLAVES  (NB_SLAVES),
      .MASTER_IDX (m)
    ) u_router (
      .r_valid_i (s_r_valid_i),
      .r_id_i    (s_r_id_i),
      .r_rdata_i (s_r_rdata_i),
      .r_opc_i   (s_r_opc_i),
      .r_valid_o (m_r_valid_o[m]),
      .r_rdata_o (m_r_rdata_o[m]),
      .r_opc_o   (m_r_opc_o[m])
    );
  end

  for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_slaves
    for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_transpose
      assign arb_req[s][m] = req_mtx[m][s];
      assign gnt_mtx[m][s] = arb_gnt[s][m];
    end

    periph_rr_arbiter #(
      .NB_MASTERS (NB_MASTERS)
    ) u_arbiter (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (arb_req[s]),
      .add_i    (m_add_i),
      .wen_i    (m_wen_i),
      .wdata_i  (m_wdata_i),
      .be_i     (m_be_i),
      .gnt_o    (arb_gnt[s]),
      .gnt_i    (s_gnt_i[s]),
      .req_o    (s_req_o[s]),
      .add_o    (s_add_o[s]),
      .wen_o    (s_wen_o[s]),
      .wdata_o  (s_wdata_o[s]),
      .be_o     (s_be_o[s]),
      .id_o     (s_id_o[s])
    );
  end

endmodule

//--- tb/periph_xbar_assert.sv
/*
 * Concurrent assertions on one slave-port arbiter
 * Bound to every periph_rr_arbiter instance
 */

`timescale 1ns/1ps

module periph_xbar_assert #(
  parameter int unsigned NB_MASTERS = 4
) (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic [NB_MASTERS-1:0] req_vec_i,
  input logic                  req_i,
  input logic                  gnt_i,
  input logic [NB_MASTERS-1:0] gnt_o_i,
  input logic [NB_MASTERS-1:0] id_i
);

  // Never more than one master granted
  assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(gnt_o_i))
    else $error("arbiter granted more than one master");

  // A grant needs the slave grant and goes only to a requesting master
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   (|gnt_o_i) |-> (req_i && gnt_i && ((gnt_o_i & ~req_vec_i) == '0)))
    else $error("arbiter grant without request or slave grant");

  // Id sent to the slave names the granted master
  assert property (@(posedge clk_i) disable iff (!arst_n_i) (|gnt_o_i) |-> (id_i == gnt_o_i))
    else $error("arbiter id does not match granted master");

  // While the slave sees a request, the id names exactly one requesting master
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   req_i |-> ($onehot(id_i) && ((id_i & req_vec_i) != '0)))
    else $error("arbiter id does not name a requesting master");

endmodule

bind periph_rr_arbiter periph_xbar_assert #(
  .NB_MASTERS (NB_MASTERS)
) u_assert (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .req_vec_i (req_i),
  .req_i     (req_o),
  .gnt_i     (gnt_i),
  .gnt_o_i   (gnt_o),
  .id_i      (id_o)
);

//--- tb/periph_xbar_checker.sv
/*
 * Checker for the peripheral crossbar
 * Predicts the target slave, checks pass-through fields, responses,
 * round-robin fairness and quiet reset, and counts errors
 */

`timescale 1ns/1ps

module periph_xbar_checker #(
  parameter int unsigned NB_MASTERS = 4,
  parameter int unsigned NB_SLAVES  = 8
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [NB_MASTERS-1:0][127:0]          name_i,
  input  logic [NB_MASTERS-1:0]                 m_req_i,
  input  logic [NB_MASTERS-1:0][31:0]           m_add_i,
  input  logic [NB_MASTERS-1:0]                 m_wen_i,
  input  logic [NB_MASTERS-1:0][31:0]           m_wdata_i,
  input  logic [NB_MASTERS-1:0][3:0]            m_be_i,
  input  logic [NB_MASTERS-1:0]                 m_gnt_i,
  input  logic [NB_MASTERS-1:0]                 m_r_valid_i,
  input  logic [NB_MASTERS-1:0][31:0]           m_r_rdata_i,
  input  logic [NB_MASTERS-1:0]                 m_r_opc_i,
  input  logic [NB_SLAVES-1:0]                  s_req_i,
  input  logic [NB_SLAVES-1:0][31:0]            s_add_i,
  input  logic [NB_SLAVES-1:0]                  s_wen_i,
  input  logic [NB_SLAVES-1:0][31:0]            s_wdata_i,
  input  logic [NB_SLAVES-1:0][3:0]             s_be_i,
  input  logic [NB_SLAVES-1:0][NB_MASTERS-1:0]  s_id_i,
  input  logic [NB_SLAVES-1:0]                  s_gnt_i,
  output int                                    err_cnt_o
);

  int              pend_slave [NB_MASTERS];
  logic [31:0]     pend_addr  [NB_MASTERS];
  logic            pend_v     [NB_MASTERS];
  int              last_win   [NB_SLAVES];
  logic [NB_MASTERS-1:0] waiting_q [NB_SLAVES];
  int              quiet_errs = 0;
  int              data_errs  = 0;

  assign err_cnt_o = quiet_errs + data_errs;

  // Address map of this bench: HWPE absent, alias window at top byte 0x1B
  function automatic int predict_slave(input logic [31:0] addr);
    logic [3:0] idx;
    idx = addr[19:16];
    if (addr[31:24] != 8'h10 && addr[31:24] != 8'h1B) return 6;
    if (addr[23:20] != 4'h2) return 7;
    if (idx == 4'd2 || idx == 4'd3) return 2;
    if (idx == 4'd4) return 7;
    if (idx >= 4'd8) return 7;
    return int'({28'd0, idx});
  endfunction

  initial begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      pend_v[m] = 1'b0;
      pend_slave[m] = 0;
      pend_addr[m] = '0;
    end
    for (int s = 0; s < NB_SLAVES; s++) begin
      last_win[s] = -1;
      waiting_q[s] = '0;
    end
  end

  // Nothing may move on the slave side while no master requests
  always @(negedge clk_i) begin
    if (m_req_i == '0 && (s_req_i != '0 || m_gnt_i != '0)) begin
      $display("Error: slave request or master grant active with no master requesting");
      quiet_errs++;
    end
  end

  always @(posedge clk_i) begin
    int exp_slv;
    int act_slv;
    int win;
    logic [NB_MASTERS-1:0] col;
    logic [31:0] exp_data;
    if (arst_n_i) begin
      for (int m = 0; m < NB_MASTERS; m++) begin
        if (m_r_valid_i[m]) begin
          if (!pend_v[m]) begin
            $display("Error: master %0d got a response it never asked for", m);
            data_errs++;
          end else begin
            exp_data = pend_addr[m] ^ pend_slave[m];
            if (m_r_rdata_i[m] != exp_data) begin
              $display("Fail %0s: rdata expected %h actual %h", name_i[m], exp_data,
                       m_r_rdata_i[m]);
              data_errs++;
            end
            if (m_r_opc_i[m] != (pend_slave[m] == 7)) begin
              $display("Fail %0s: r_opc expected %0d actual %0d", name_i[m],
                       (pend_slave[m] == 7), m_r_opc_i[m]);
              data_errs++;
            end
            pend_v[m] = 1'b0;
          end
        end
      end

      // Fairness per slave port
      for (int s = 0; s < NB_SLAVES; s++) begin
        for (int m = 0; m < NB_MASTERS; m++) begin
          col[m] = m_req_i[m] && (predict_slave(m_add_i[m]) == s);
        end
        if (s_req_i[s] && s_gnt_i[s]) begin
          win = -1;
          for (int m = 0; m < NB_MASTERS; m++) begin
            if (s_id_i[s][m]) win = m;
          end
          if (last_win[s] == win && (waiting_q[s] & col) != '0) begin
            $display("Error: slave %0d granted master %0d twice while others waited", s, win);
            data_errs++;
          end
          last_win[s] = win;
          waiting_q[s] = col & ~s_id_i[s];
        end
      end

      for (int m = 0; m < NB_MASTERS; m++) begin
        if (m_req_i[m] && m_gnt_i[m]) begin
          exp_slv = predict_slave(m_add_i[m]);
          act_slv = -1;
          for (int s = 0; s < NB_SLAVES; s++) begin
            if (s_req_i[s] && s_gnt_i[s] && s_id_i[s][m]) act_slv = s;
          end
          if (act_slv != exp_slv) begin
            $display("Fail %0s: slave expected %0d actual %0d", name_i[m], exp_slv, act_slv);
            data_errs++;
          end else begin
            if (s_add_i[exp_slv] != m_add_i[m]) begin
              $display("Fail %0s: s_add expected %h actual %h", name_i[m], m_add_i[m],
                       s_add_i[exp_slv]);
              data_errs++;
            end
            if (s_wen_i[exp_slv] != m_wen_i[m]) begin
              $display("Fail %0s: s_wen expected %0d actual %0d", name_i[m], m_wen_i[m],
                       s_wen_i[exp_slv]);
              data_errs++;
            end
            if (s_wdata_i[exp_slv] != m_wdata_i[m]) begin
              $display("Fail %0s: s_wdata expected %h actual %h", name_i[m], m_wdata_i[m],
                       s_wdata_i[exp_slv]);
              data_errs++;
            end
            if (s_be_i[exp_slv] != m_be_i[m]) begin
              $display("Fail %0s: s_be expected %h actual %h", name_i[m], m_be_i[m],
                       s_be_i[exp_slv]);
              data_errs++;
            end
          end
          pend_v[m] = 1'b1;
          pend_slave[m] = exp_slv;
          pend_addr[m] = m_add_i[m];
        end
      end
    end
  end

endmodule

//--- tb/tb_periph_xbar.sv
/*
 * Testbench for the peripheral crossbar
 * Clock, reset, slave models, stimulus table and closing report
 */

`timescale 1ns/1ps

module tb_periph_xbar;

  localparam int unsigned NB_MASTERS = 4;
  localparam int unsigned NB_SLAVES  = 8;
  localparam int unsigned NTESTS     = 10;
  localparam int unsigned TIMEOUT    = 100;

  // Directed table: name, master, address, wen, wdata, expected slave
  localparam logic [127:0] T_NAME [NTESTS] = '{
    "reg_port0", "reg_port1", "eu_collapse", "hwpe_absent", "region_3",
    "cluster_other", "index_9", "external", "alias_port0", "reg_port5"};
  localparam int T_MASTER [NTESTS] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 1};
  localparam logic [31:0] T_ADDR [NTESTS] = '{
    32'h1020_0000, 32'h1021_0004, 32'h1023_0000, 32'h1024_0000, 32'h1030_0000,
    32'h1000_1000, 32'h1029_0000, 32'h2000_0000, 32'h1B20_0000, 32'h1025_0010};
  localparam logic T_WEN [NTESTS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1,
                                      1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
  localparam logic [31:0] T_WDATA [NTESTS] = '{
    32'hA5A5_0001, 32'h0, 32'hA5A5_0003, 32'h0, 32'h0,
    32'hA5A5_0006, 32'h0, 32'hA5A5_0008, 32'h0, 32'hA5A5_000A};
  localparam int T_SLAVE [NTESTS] = '{0, 1, 2, 7, 7, 7, 7, 6, 0, 5};

  logic clk_i;
  logic arst_n_i;
  logic [NB_MASTERS-1:0]                 m_req_i;
  logic [NB_MASTERS-1:0][31:0]           m_add_i;
  logic [NB_MASTERS-1:0]                 m_wen_i;
  logic [NB_MASTERS-1:0][31:0]           m_wdata_i;
  logic [NB_MASTERS-1:0][3:0]            m_be_i;
  logic [NB_MASTERS-1:0]                 m_gnt_o;
  logic [NB_MASTERS-1:0]                 m_r_valid_o;
  logic [NB_MASTERS-1:0][31:0]           m_r_rdata_o;
  logic [NB_MASTERS-1:0]                 m_r_opc_o;
  logic [NB_SLAVES-1:0]                  s_req_o;
  logic [NB_SLAVES-1:0][31:0]            s_add_o;
  logic [NB_SLAVES-1:0]                  s_wen_o;
  logic [NB_SLAVES-1:0][31:0]            s_wdata_o;
  logic [NB_SLAVES-1:0][3:0]             s_be_o;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0]  s_id_o;
  logic [NB_SLAVES-1:0]                  s_gnt_i;
  logic [NB_SLAVES-1:0]                  s_r_valid_i;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0]  s_r_id_i;
  logic [NB_SLAVES-1:0][31:0]            s_r_rdata_i;
  logic [NB_SLAVES-1:0]                  s_r_opc_i;
  logic [NB_MASTERS-1:0][127:0]          cur_name;
  int                                    chk_errs;
  int                                    tb_errs;

  periph_xbar #(
    .NB_MASTERS         (NB_MASTERS),
    .NB_SLAVES          (NB_SLAVES),
    .HWPE_PRESENT       (1'b0),
    .CLUSTER_ALIAS      (1'b1),
    .CLUSTER_ALIAS_BASE (12'h1B0)
  ) u_periph_xbar (
    .clk_i, .arst_n_i, .m_req_i, .m_add_i, .m_wen_i, .m_wdata_i, .m_be_i,
    .m_gnt_o, .m_r_valid_o, .m_r_rdata_o, .m_r_opc_o,
    .s_req_o, .s_add_o, .s_wen_o, .s_wdata_o, .s_be_o, .s_id_o, .s_gnt_i,
    .s_r_valid_i, .s_r_id_i, .s_r_rdata_i, .s_r_opc_i
  );

  periph_xbar_checker #(
    .NB_MASTERS (NB_MASTERS),
    .NB_SLAVES  (NB_SLAVES)
  ) u_checker (
    .clk_i, .arst_n_i, .name_i (cur_name), .m_req_i, .m_add_i, .m_wen_i, .m_wdata_i,
    .m_be_i, .m_gnt_i (m_gnt_o), .m_r_valid_i (m_r_valid_o), .m_r_rdata_i (m_r_rdata_o),
    .m_r_opc_i (m_r_opc_o), .s_req_i (s_req_o), .s_add_i (s_add_o), .s_wen_i (s_wen_o),
    .s_wdata_i (s_wdata_o), .s_be_i (s_be_o), .s_id_i (s_id_o), .s_gnt_i,
    .err_cnt_o (chk_errs)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Slave models: grant after 0..3 cycles, answer one cycle later
  for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_slave
    logic gnt;
    logic rv;
    logic ropc;
    logic [NB_MASTERS-1:0] rid;
    logic [31:0] rdata;

    assign s_gnt_i[s]     = gnt;
    assign s_r_valid_i[s] = rv;
    assign s_r_id_i[s]    = rid;
    assign s_r_rdata_i[s] = rdata;
    assign s_r_opc_i[s]   = ropc;

    initial begin
      logic hs;
      logic [NB_MASTERS-1:0] cap_id;
      logic [31:0] cap_add;
      int unsigned dly;
      gnt = 1'b0;
      rv = 1'b0;
      ropc = 1'b0;
      rid = '0;
      rdata = '0;
      dly = 0;
      forever begin
        @(posedge clk_i);
        hs = arst_n_i && gnt && s_req_o[s];
        cap_id = s_id_o[s];
        cap_add = s_add_o[s];
        #2;
        rv = hs;
        rid = hs ? cap_id : '0;
        rdata = hs ? (cap_add ^ 32'(s)) : '0;
        ropc = hs && (s == 7);
        if (hs) begin
          gnt = 1'b0;
          dly = $urandom % 4;
        end else if (arst_n_i && s_req_o[s] && !gnt) begin
          if (dly == 0) gnt = 1'b1;
          else dly--;
        end
      end
    end
  end

  // One request from one master: wait for grant, then for its response
  task automatic issue(input int m, input logic [127:0] name, input logic [31:0] addr,
                       input logic wen, input logic [31:0] wdata, input int exp_slv);
    int cnt;
    logic [31:0] exp_data;
    exp_data = addr ^ 32'(exp_slv);
    @(posedge clk_i);
    #1;
    cur_name[m] = name;
    m_add_i[m] = addr;
    m_wen_i[m] = wen;
    m_wdata_i[m] = wdata;
    m_req_i[m] = 1'b1;
    cnt = 0;
    do begin
      @(posedge clk_i);
      cnt++;
    end while (!m_gnt_o[m] && cnt < TIMEOUT);
    #1;
    m_req_i[m] = 1'b0;
    if (cnt >= TIMEOUT) begin
      $display("Error: %0s on master %0d was never granted", name, m);
      tb_errs++;
    end else begin
      cnt = 0;
      do begin
        @(posedge clk_i);
        cnt++;
      end while (!m_r_valid_o[m] && cnt < TIMEOUT);
      if (cnt >= TIMEOUT) begin
        $display("Error: %0s on master %0d got no response", name, m);
        tb_errs++;
      end else if (m_r_rdata_o[m] != exp_data) begin
        $display("Fail %0s: rdata expected %h actual %h", name, exp_data, m_r_rdata_o[m]);
        tb_errs++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'had9b));
    tb_errs = 0;
    arst_n_i = 1'b0;
    m_req_i = '0;
    m_add_i = '0;
    m_wen_i = '1;
    m_wdata_i = '0;
    // One byte lane per master keeps the byte enables of all masters distinct
    for (int m = 0; m < NB_MASTERS; m++) begin
      m_be_i[m] = 4'(1 << m);
    end
    cur_name = '0;
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    repeat (3) @(posedge clk_i);

    for (int i = 0; i < NTESTS; i++) begin
      issue(T_MASTER[i], T_NAME[i], T_ADDR[i], T_WEN[i], T_WDATA[i], T_SLAVE[i]);
    end

    // All masters compete for port 1
    for (int m = 0; m < NB_MASTERS; m++) begin
      fork
        automatic int mm = m;
        begin
          repeat (3) issue(mm, "rr_contend", 32'h1021_0000 + 32'(mm * 4), 1'b1, '0, 1);
        end
      join_none
    end
    wait fork;

    repeat (5) @(posedge clk_i);
    $display("Errors: checker %0d, testbench %0d", chk_errs, tb_errs);
    if (chk_errs == 0 && tb_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- periph_xbar.f
source/periph_xbar_pkg.sv
source/periph_addr_decode.sv
source/periph_rr_arbiter.sv
source/periph_resp_router.sv
source/periph_xbar.sv
tb/periph_xbar_assert.sv
tb/periph_xbar_checker.sv
tb/tb_periph_xbar.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=build/obj
LOG=sim.log

mkdir -p "$OBJ_DIR"
if [ $? -ne 0 ]; then
  echo "Cannot create $OBJ_DIR"
  exit 1
fi

verilator --binary --timing --assert \
  --top-module tb_periph_xbar \
  -Mdir "$OBJ_DIR" \
  -f periph_xbar.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$OBJ_DIR/Vtb_periph_xbar" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
exit 0
